/* common/ncpu_dec_exe_if.sv */
////////////////////////////////////////
// Decode to execute control
////////////////////////////////////////
`timescale 1ns/1ps

interface ncpu_dec_exe_if;
   import ncpu_pkg::*;

   lu_op_t      lu_op;
   au_op_t      au_op;
   logic        load;
   logic        store;
   logic        use_imm;
   logic        imm_signed;
   logic [15:0] imm16;
   logic        wb_en;
   reg_addr_t   wb_addr;

   modport source (output lu_op, au_op, load, store, use_imm, imm_signed, imm16,
                   wb_en, wb_addr);
   modport sink (input lu_op, au_op, load, store, use_imm, imm_signed, imm16,
                 wb_en, wb_addr);

endinterface

/* common/ncpu_pkg.sv */
////////////////////////////////////////
// Core widths, fields and opcodes
////////////////////////////////////////

package ncpu_pkg;

   // Datapath widths
   localparam int dw     = 32;
   localparam int aw     = 32;
   localparam int iw     = 32;
   localparam int reg_aw = 5;

   localparam logic [aw-1:0] reset_vector = '0;

   // Instruction fields
   localparam int opc_lsb = 0;
   localparam int opc_msb = 5;
   localparam int rd_lsb  = 6;
   localparam int rd_msb  = 10;
   localparam int rs1_lsb = 11;
   localparam int rs1_msb = 15;
   localparam int rs2_lsb = 16;
   localparam int rs2_msb = 20;
   localparam int imm_lsb = 16;
   localparam int imm_msb = 31;

   typedef enum logic [5:0] {
      op_nop   = 6'd0,
      op_and   = 6'd1,
      op_and_i = 6'd2,
      op_or    = 6'd3,
      op_or_i  = 6'd4,
      op_xor   = 6'd5,
      op_xor_i = 6'd6,
      op_lsl   = 6'd7,
      op_lsl_i = 6'd8,
      op_lsr   = 6'd9,
      op_lsr_i = 6'd10,
      op_asr   = 6'd11,
      op_asr_i = 6'd12,
      op_add   = 6'd13,
      op_add_i = 6'd14,
      op_sub   = 6'd15,
      op_ldw   = 6'd16,
      op_stw   = 6'd17
   } opcode_t;

   // One-hot logic unit select, bit positions below
   typedef logic [5:0] lu_op_t;
   localparam int lu_and = 0;
   localparam int lu_or  = 1;
   localparam int lu_xor = 2;
   localparam int lu_lsl = 3;
   localparam int lu_lsr = 4;
   localparam int lu_asr = 5;

   // One-hot adder select
   typedef logic [1:0] au_op_t;
   localparam int au_add = 0;
   localparam int au_sub = 1;

   typedef logic [dw-1:0]     word_t;
   typedef logic [reg_aw-1:0] reg_addr_t;

endpackage

/* common/ncpu_regf_if.sv */
////////////////////////////////////////
// Register file ports
////////////////////////////////////////
`timescale 1ns/1ps

interface ncpu_regf_if;
   import ncpu_pkg::*;

   // Read side
   reg_addr_t rs1_addr;
   reg_addr_t rs2_addr;
   logic      rd_en;
   word_t     rs1_data;
   word_t     rs2_data;

   // Writeback side
   logic      wb_en;
   reg_addr_t wb_addr;
   word_t     wb_data;

   modport decode (output rs1_addr, rs2_addr, rd_en);
   modport execute (input rs1_data, rs2_data, output wb_en, wb_addr, wb_data);
   modport regfile (input rs1_addr, rs2_addr, rd_en, wb_en, wb_addr, wb_data,
                    output rs1_data, rs2_data);

endinterface

/* execute/ncpu_execute.sv */
////////////////////////////////////////
// Execute and writeback
////////////////////////////////////////
`timescale 1ns/1ps

module ncpu_execute (
   input  ncpu_pkg::word_t         d_i,
   input  logic                    dbus_rd_ready_i,
   input  logic                    dbus_we_done_i,
   input  logic                    exe_flow_i,
   output ncpu_pkg::word_t         d_o,
   output logic [ncpu_pkg::aw-1:0] addr_o,
   output logic                    dbus_rd_o,
   output logic                    dbus_we_o,
   ncpu_dec_exe_if.sink            dex,
   ncpu_regf_if.execute            regf
);
   import ncpu_pkg::*;

   word_t imm_ext;
   word_t op2;
   word_t adder_b;
   word_t adder_out;
   word_t lu_result;
   logic  adder_sub;
   logic  mem_op;
   logic  mem_ack;

   assign imm_ext = dex.imm_signed ? {{(dw-16){dex.imm16[15]}}, dex.imm16}
                                   : {{(dw-16){1'b0}}, dex.imm16};
   assign op2 = dex.use_imm ? imm_ext : regf.rs2_data;

   ncpu_logic_unit u_logic_unit (
      .lu_op_i  (dex.lu_op),
      .op1_i    (regf.rs1_data),
      .op2_i    (op2),
      .result_o (lu_result)
   );

   // Subtract as add of the complement plus one
   assign adder_sub = dex.au_op[au_sub];
   assign adder_b   = adder_sub ? ~op2 : op2;
   assign adder_out = regf.rs1_data + adder_b + word_t'(adder_sub);

   ////////////////////////////////////////
   // Memory access
   ////////////////////////////////////////
   // Adder select is zero for loads and stores, so this is rs1 plus imm
   assign addr_o    = adder_out[aw-1:0];
   assign d_o       = regf.rs2_data;
   assign dbus_rd_o = dex.load;
   assign dbus_we_o = dex.store;

   assign mem_op  = dex.load | dex.store;
   assign mem_ack = (dex.load & dbus_rd_ready_i) | (dex.store & dbus_we_done_i);

   // Only one source is selected per instruction
   assign regf.wb_data = lu_result
                       | ({dw{|dex.au_op}} & adder_out)
                       | ({dw{dex.load}} & d_i);
   assign regf.wb_addr = dex.wb_addr;
   assign regf.wb_en   = dex.wb_en & exe_flow_i & (~mem_op | mem_ack);

endmodule

/* execute/ncpu_logic_unit.sv */
////////////////////////////////////////
// Logic and shift unit
////////////////////////////////////////
`timescale 1ns/1ps

module ncpu_logic_unit (
   input  ncpu_pkg::lu_op_t lu_op_i,
   input  ncpu_pkg::word_t  op1_i,
   input  ncpu_pkg::word_t  op2_i,
   output ncpu_pkg::word_t  result_o
);
   import ncpu_pkg::*;

   word_t           shift_in;
   word_t           shift_fill;
   word_t           shift_out;
   word_t           shift_res;
   logic [2*dw-1:0] shift_wide;
   logic            is_shift;

   function automatic word_t reverse_bits(input word_t a);
      word_t r;
      for (int i = 0; i < dw; i++) begin
         r[dw-1-i] = a[i];
      end
      return r;
   endfunction

   // Left shift runs through the right shifter on reversed bits
   assign shift_in   = lu_op_i[lu_lsl] ? reverse_bits(op1_i) : op1_i;
   assign shift_fill = lu_op_i[lu_asr] ? {dw{op1_i[dw-1]}} : '0;
   assign shift_wide = {shift_fill, shift_in} >> op2_i[4:0];
   assign shift_out  = shift_wide[dw-1:0];
   assign shift_res  = lu_op_i[lu_lsl] ? reverse_bits(shift_out) : shift_out;
   assign is_shift   = lu_op_i[lu_lsl] | lu_op_i[lu_lsr] | lu_op_i[lu_asr];

   // Zero when no logic op is selected
   assign result_o = ({dw{lu_op_i[lu_and]}} & (op1_i & op2_i))
                   | ({dw{lu_op_i[lu_or]}}  & (op1_i | op2_i))
                   | ({dw{lu_op_i[lu_xor]}} & (op1_i ^ op2_i))
                   | ({dw{is_shift}}        & shift_res);

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_ncpu_core \
   --Mdir obj_dir -o sim_tb_ncpu_core
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/sim_tb_ncpu_core)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "=== PASS ===" <<< "$output"; then
   exit 0
fi
exit 1

/* src/ncpu_core.sv */
////////////////////////////////////////
// Three-stage core top
////////////////////////////////////////
`timescale 1ns/1ps

module ncpu_core (
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   input  ncpu_pkg::word_t         d_i,
   input  logic [ncpu_pkg::iw-1:0] insn_i,
   input  logic                    insn_ready_i,
   input  logic                    dbus_rd_ready_i,
   input  logic                    dbus_we_done_i,
   output ncpu_pkg::word_t         d_o,
   output logic [ncpu_pkg::aw-1:0] addr_o,
   output logic                    dbus_rd_o,
   output logic                    dbus_we_o,
   output logic [ncpu_pkg::aw-1:0] iaddr_o,
   output logic                    ibus_rd_o
);
   import ncpu_pkg::*;

   logic [iw-1:0] dec_insn;
   logic          exe_flow;
   logic          dec_flow;
   logic          fetch_flow;

   ncpu_regf_if    regf ();
   ncpu_dec_exe_if dex ();

   ////////////////////////////////////////
   // Flow control
   ////////////////////////////////////////
   // Memory ops hold the whole pipe until the bus answers
   assign exe_flow   = ~(dex.load | dex.store) | dbus_rd_ready_i | dbus_we_done_i;
   assign dec_flow   = exe_flow;
   assign fetch_flow = dec_flow & insn_ready_i;
   assign ibus_rd_o  = 1'b1;

   ncpu_fetch u_fetch (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .insn_i       (insn_i),
      .fetch_flow_i (fetch_flow),
      .iaddr_o      (iaddr_o),
      .dec_insn_o   (dec_insn)
   );

   ncpu_decode u_decode (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .dec_insn_i (dec_insn),
      .dec_flow_i (dec_flow),
      .regf       (regf),
      .dex        (dex)
   );

   ncpu_regfile u_regfile (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .regf    (regf)
   );

   ncpu_execute u_execute (
      .d_i             (d_i),
      .dbus_rd_ready_i (dbus_rd_ready_i),
      .dbus_we_done_i  (dbus_we_done_i),
      .exe_flow_i      (exe_flow),
      .d_o             (d_o),
      .addr_o          (addr_o),
      .dbus_rd_o       (dbus_rd_o),
      .dbus_we_o       (dbus_we_o),
      .dex             (dex),
      .regf            (regf)
   );

endmodule

/* src/ncpu_decode.sv */
////////////////////////////////////////
// Instruction decode
////////////////////////////////////////
`timescale 1ns/1ps

module ncpu_decode (
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   input  logic [ncpu_pkg::iw-1:0] dec_insn_i,
   input  logic                    dec_flow_i,
   ncpu_regf_if.decode             regf,
   ncpu_dec_exe_if.source          dex
);
   import ncpu_pkg::*;

   opcode_t     opcode;
   reg_addr_t   f_rd;
   reg_addr_t   f_rs1;
   reg_addr_t   f_rs2;
   logic [15:0] f_imm16;
   lu_op_t      lu_op;
   au_op_t      au_op;
   logic        load;
   logic        store;
   logic        use_imm;
   logic        imm_signed;
   logic        wb_en;

   assign opcode  = opcode_t'(dec_insn_i[opc_msb:opc_lsb]);
   assign f_rd    = dec_insn_i[rd_msb:rd_lsb];
   assign f_rs1   = dec_insn_i[rs1_msb:rs1_lsb];
   assign f_rs2   = dec_insn_i[rs2_msb:rs2_lsb];
   assign f_imm16 = dec_insn_i[imm_msb:imm_lsb];

   ////////////////////////////////////////
   // Unit selects
   ////////////////////////////////////////
   assign lu_op[lu_and] = opcode inside {op_and, op_and_i};
   assign lu_op[lu_or]  = opcode inside {op_or, op_or_i};
   assign lu_op[lu_xor] = opcode inside {op_xor, op_xor_i};
   assign lu_op[lu_lsl] = opcode inside {op_lsl, op_lsl_i};
   assign lu_op[lu_lsr] = opcode inside {op_lsr, op_lsr_i};
   assign lu_op[lu_asr] = opcode inside {op_asr, op_asr_i};

   assign au_op[au_add] = opcode inside {op_add, op_add_i};
   assign au_op[au_sub] = (opcode == op_sub);

   assign load  = (opcode == op_ldw);
   assign store = (opcode == op_stw);

   assign use_imm = opcode inside {op_and_i, op_or_i, op_xor_i, op_lsl_i, op_lsr_i,
                                   op_asr_i, op_add_i, op_ldw, op_stw};
   assign imm_signed = opcode inside {op_and_i, op_xor_i, op_add_i, op_ldw, op_stw};

   // Unknown opcodes leave every select low and act as no-ops
   assign wb_en = (|lu_op) | (|au_op) | load;

   // Operand requests, store data comes from rd
   assign regf.rs1_addr = f_rs1;
   assign regf.rs2_addr = store ? f_rd : f_rs2;
   assign regf.rd_en    = dec_flow_i;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         dex.lu_op      <= '0;
         dex.au_op      <= '0;
         dex.load       <= 1'b0;
         dex.store      <= 1'b0;
         dex.use_imm    <= 1'b0;
         dex.imm_signed <= 1'b0;
         dex.wb_en      <= 1'b0;
      end else if (dec_flow_i) begin
         dex.lu_op      <= lu_op;
         dex.au_op      <= au_op;
         dex.load       <= load;
         dex.store      <= store;
         dex.use_imm    <= use_imm;
         dex.imm_signed <= imm_signed;
         dex.wb_en      <= wb_en;
      end
   end

   // Payload fields
   always_ff @(posedge clk_i) begin
      if (dec_flow_i) begin
         dex.imm16   <= f_imm16;
         dex.wb_addr <= f_rd;
      end
   end

endmodule

/* src/ncpu_fetch.sv */
////////////////////////////////////////
// Instruction fetch
////////////////////////////////////////
`timescale 1ns/1ps

module ncpu_fetch (
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   input  logic [ncpu_pkg::iw-1:0] insn_i,
   input  logic                    fetch_flow_i,
   output logic [ncpu_pkg::aw-1:0] iaddr_o,
   output logic [ncpu_pkg::iw-1:0] dec_insn_o
);
   import ncpu_pkg::*;

   logic [aw-1:0] pc_q;

   // PC and decode register move together
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         pc_q       <= reset_vector;
         dec_insn_o <= iw'(op_nop);
      end else if (fetch_flow_i) begin
         pc_q       <= pc_q + aw'(4);
         dec_insn_o <= insn_i;
      end
   end

   assign iaddr_o = pc_q;

endmodule

/* src/ncpu_regfile.sv */
////////////////////////////////////////
// Register file
////////////////////////////////////////
`timescale 1ns/1ps

module ncpu_regfile (
   input  logic         clk_i,
   input  logic         rst_n_i,
   ncpu_regf_if.regfile regf
);
   import ncpu_pkg::*;

   localparam int n_regs = 2 ** reg_aw;

   word_t regs [n_regs];
   word_t rs1_fwd;
   word_t rs2_fwd;
   logic  rs1_hit;
   logic  rs2_hit;

   // Write bypass for a read at the same edge
   assign rs1_hit = regf.wb_en && (regf.wb_addr == regf.rs1_addr);
   assign rs2_hit = regf.wb_en && (regf.wb_addr == regf.rs2_addr);
   assign rs1_fwd = rs1_hit ? regf.wb_data : regs[regf.rs1_addr];
   assign rs2_fwd = rs2_hit ? regf.wb_data : regs[regf.rs2_addr];

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < n_regs; i++) begin
            regs[i] <= '0;
         end
         regf.rs1_data <= '0;
         regf.rs2_data <= '0;
      end else begin
         if (regf.wb_en) begin
            regs[regf.wb_addr] <= regf.wb_data;
         end
         // Read data holds while the strobe is low
         if (regf.rd_en) begin
            regf.rs1_data <= rs1_fwd;
            regf.rs2_data <= rs2_fwd;
         end
      end
   end

endmodule

/* testbench/ncpu_checker.sv */
////////////////////////////////////////
// Store and load checker
////////////////////////////////////////
`timescale 1ns/1ps

module ncpu_checker (
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   input  logic [ncpu_pkg::aw-1:0] dbus_addr_i,
   input  ncpu_pkg::word_t         dbus_wdata_i,
   input  logic                    dbus_rd_i,
   input  logic                    dbus_we_i,
   input  logic                    dbus_rd_ready_i,
   input  logic                    dbus_we_done_i,
   output int                      err_count_o,
   output int                      store_count_o,
   output int                      exp_count_o
);
   import ncpu_pkg::*;

   localparam int max_prog = 512;

   logic [iw-1:0] prog [max_prog];
   int            prog_len;
   word_t         exp_st_addr [$];
   word_t         exp_st_data [$];
   word_t         exp_ld_addr [$];
   int            exp_count;
   int            store_idx;
   int            load_idx;
   int            errors;
   logic          pend;
   word_t         held_addr;
   word_t         held_data;

   // Same address mix as the bus model
   function automatic word_t load_data(input word_t a);
      return {a[15:0], a[31:16]} ^ 32'hc3a5_5a3c;
   endfunction

   // Sequential model of the program
   function automatic void predict();
      word_t         regs [32];
      word_t         a;
      word_t         b;
      word_t         si;
      word_t         ui;
      word_t         res;
      word_t         addr;
      logic [iw-1:0] w;
      logic          wr;
      for (int r = 0; r < 32; r++) begin
         regs[r] = '0;
      end
      exp_st_addr.delete();
      exp_st_data.delete();
      exp_ld_addr.delete();
      for (int i = 0; i < prog_len; i++) begin
         w   = prog[i];
         a   = regs[w[rs1_msb:rs1_lsb]];
         b   = regs[w[rs2_msb:rs2_lsb]];
         si  = {{16{w[imm_msb]}}, w[imm_msb:imm_lsb]};
         ui  = {16'h0000, w[imm_msb:imm_lsb]};
         wr  = 1'b1;
         res = '0;
         case (w[opc_msb:opc_lsb])
            op_and:   res = a & b;
            op_and_i: res = a & si;
            op_or:    res = a | b;
            op_or_i:  res = a | ui;
            op_xor:   res = a ^ b;
            op_xor_i: res = a ^ si;
            op_lsl:   res = a << b[4:0];
            op_lsl_i: res = a << ui[4:0];
            op_lsr:   res = a >> b[4:0];
            op_lsr_i: res = a >> ui[4:0];
            op_asr:   res = word_t'($signed(a) >>> b[4:0]);
            op_asr_i: res = word_t'($signed(a) >>> ui[4:0]);
            op_add:   res = a + b;
            op_add_i: res = a + si;
            op_sub:   res = a - b;
            op_ldw: begin
               addr = a + si;
               exp_ld_addr.push_back(addr);
               res = load_data(addr);
            end
            op_stw: begin
               exp_st_addr.push_back(a + si);
               exp_st_data.push_back(regs[w[rd_msb:rd_lsb]]);
               wr = 1'b0;
            end
            default: wr = 1'b0;
         endcase
         if (wr) begin
            regs[w[rd_msb:rd_lsb]] = res;
         end
      end
      exp_count = exp_st_addr.size();
   endfunction

   task automatic set_word(input int idx, input logic [iw-1:0] w);
      prog[idx] = w;
   endtask

   task automatic start_test(input int len);
      prog_len = len;
      predict();
   endtask

   initial begin
      errors = 0;
      store_idx = 0;
      load_idx = 0;
      pend = 1'b0;
      prog_len = 0;
      exp_count = 0;
   end

   ////////////////////////////////////////
   // Compare at the falling edge
   ////////////////////////////////////////
   always @(negedge clk_i) begin
      if (!rst_n_i) begin
         store_idx = 0;
         load_idx = 0;
         pend = 1'b0;
      end else begin
         if (dbus_we_i && dbus_we_done_i) begin
            if (store_idx >= exp_st_addr.size()) begin
               $display("FAIL %0t: unexpected store to %h", $time, dbus_addr_i);
               errors++;
            end else if (dbus_addr_i !== exp_st_addr[store_idx] ||
                         dbus_wdata_i !== exp_st_data[store_idx]) begin
               $display("FAIL %0t: store %0d got %h <- %h, expected %h <- %h", $time,
                        store_idx, dbus_addr_i, dbus_wdata_i, exp_st_addr[store_idx],
                        exp_st_data[store_idx]);
               errors++;
            end
            store_idx++;
         end
         if (dbus_rd_i && dbus_rd_ready_i) begin
            if (load_idx >= exp_ld_addr.size() || dbus_addr_i !== exp_ld_addr[load_idx]) begin
               $display("FAIL %0t: load %0d from unexpected address %h", $time, load_idx,
                        dbus_addr_i);
               errors++;
            end
            load_idx++;
         end
         // Request must hold still until answered
         if (pend) begin
            if (!(dbus_rd_i || dbus_we_i) || dbus_addr_i !== held_addr ||
                (dbus_we_i && dbus_wdata_i !== held_data)) begin
               $display("FAIL %0t: bus request changed while stalled", $time);
               errors++;
            end
         end
         pend = (dbus_rd_i && !dbus_rd_ready_i) || (dbus_we_i && !dbus_we_done_i);
         held_addr = dbus_addr_i;
         held_data = dbus_wdata_i;
      end
   end

   assign err_count_o   = errors;
   assign store_count_o = store_idx;
   assign exp_count_o   = exp_count;

endmodule

/* testbench/tb_ncpu_core.sv */
////////////////////////////////////////
// Core testbench
////////////////////////////////////////
`timescale 1ns/1ps

module tb_ncpu_core;
   import ncpu_pkg::*;

   localparam int          max_prog    = 512;
   localparam int          n_logic     = 23;
   localparam int          n_arith     = 12;
   localparam int          n_mem       = 40;
   localparam int          n_rand      = 200;
   localparam int          tail_len    = 33;
   localparam int          n_tests     = 4;
   localparam int          total_insns = n_logic + n_arith + n_mem + n_rand + n_tests * tail_len;
   localparam int          limit_cycles = total_insns * 6 + 100;
   localparam logic [31:0] seed        = 32'h49ca_7026;

   logic          clk;
   logic          rst_n;
   word_t         d_i;
   logic [iw-1:0] insn_i;
   logic          insn_ready;
   logic          dbus_rd_ready;
   logic          dbus_we_done;
   word_t         d_o;
   logic [aw-1:0] addr_o;
   logic [aw-1:0] iaddr_o;
   logic          dbus_rd_o;
   logic          dbus_we_o;
   logic          ibus_rd_o;
   int            err_cnt;
   int            store_cnt;
   int            exp_cnt;
   logic [iw-1:0] prog [max_prog];
   int            prog_len;
   logic [31:0]   prog_rng;
   int            tb_errors;
   int            tests_run;
   int            tests_failed;

   ncpu_core u_dut (
      .clk_i           (clk),
      .rst_n_i         (rst_n),
      .d_i             (d_i),
      .insn_i          (insn_i),
      .insn_ready_i    (insn_ready),
      .dbus_rd_ready_i (dbus_rd_ready),
      .dbus_we_done_i  (dbus_we_done),
      .d_o             (d_o),
      .addr_o          (addr_o),
      .dbus_rd_o       (dbus_rd_o),
      .dbus_we_o       (dbus_we_o),
      .iaddr_o         (iaddr_o),
      .ibus_rd_o       (ibus_rd_o)
   );

   ncpu_checker u_checker (
      .clk_i           (clk),
      .rst_n_i         (rst_n),
      .dbus_addr_i     (addr_o),
      .dbus_wdata_i    (d_o),
      .dbus_rd_i       (dbus_rd_o),
      .dbus_we_i       (dbus_we_o),
      .dbus_rd_ready_i (dbus_rd_ready),
      .dbus_we_done_i  (dbus_we_done),
      .err_count_o     (err_cnt),
      .store_count_o   (store_cnt),
      .exp_count_o     (exp_cnt)
   );

   // Instruction memory returns a no-op past the end
   assign insn_i = (int'(iaddr_o >> 2) < prog_len) ? prog[iaddr_o[10:2]] : '0;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic word_t load_data(input word_t a);
      return {a[15:0], a[31:16]} ^ 32'hc3a5_5a3c;
   endfunction

   // Register forms pass rs2 as imm
   function automatic logic [iw-1:0] enc(input opcode_t op, input int rd, input int rs1,
                                         input int imm);
      logic [iw-1:0] w;
      w = '0;
      w[opc_msb:opc_lsb] = op;
      w[rd_msb:rd_lsb]   = 5'(rd);
      w[rs1_msb:rs1_lsb] = 5'(rs1);
      w[imm_msb:imm_lsb] = 16'(imm);
      return w;
   endfunction

   // Re-issuing the word in decode is harmless only for no-ops
   function automatic logic fetch_may_drop();
      int         idx;
      logic [5:0] op;
      if (iaddr_o == reset_vector) begin
         return 1'b1;
      end
      idx = int'(iaddr_o >> 2) - 1;
      op = (idx < prog_len) ? prog[idx][opc_msb:opc_lsb] : 6'd0;
      return (op == 6'd0) || (op > 6'd17);
   endfunction

   task automatic emit(input logic [iw-1:0] w);
      prog[prog_len] = w;
      prog_len++;
   endtask

   ////////////////////////////////////////
   // Program generators
   ////////////////////////////////////////
   task automatic logic_prog();
      emit(enc(op_or_i, 1, 1, 'h00f0));
      emit(enc(op_or_i, 2, 2, 'h0f0f));
      emit(enc(op_or_i, 3, 3, 'h8001));
      emit(enc(op_lsl_i, 4, 3, 16));
      emit(enc(op_or, 5, 4, 2));
      emit(enc(op_and, 6, 5, 3));
      emit(enc(op_and_i, 7, 5, 'hff0f));
      emit(enc(op_xor, 9, 5, 1));
      emit(enc(op_xor_i, 10, 4, 'h8000));
      emit(enc(op_lsl_i, 11, 5, 0));
      emit(enc(op_lsl_i, 12, 1, 31));
      emit(enc(op_lsr_i, 13, 5, 31));
      emit(enc(op_lsr_i, 14, 5, 0));
      emit(enc(op_asr_i, 15, 4, 31));
      emit(enc(op_asr_i, 16, 5, 4));
      emit(enc(op_asr_i, 17, 2, 3));
      emit(enc(op_or_i, 18, 18, 31));
      emit(enc(op_lsl, 19, 5, 18));
      emit(enc(op_lsr, 20, 4, 18));
      emit(enc(op_asr, 21, 12, 18));
      emit(enc(op_asr, 22, 5, 1));
      emit(enc(op_lsl, 23, 2, 1));
      emit(enc(op_and, 24, 9, 10));
   endtask

   task automatic arith_prog();
      emit(enc(op_or_i, 1, 1, 5));
      emit(enc(op_or_i, 2, 2, 9));
      emit(enc(op_sub, 3, 1, 2));
      emit(enc(op_add, 4, 3, 2));
      emit(enc(op_add_i, 5, 1, -100));
      emit(enc(op_add_i, 6, 3, 'h8000));
      emit(enc(op_sub, 7, 0, 1));
      emit(enc(op_add, 8, 7, 7));
      emit(enc(op_add_i, 9, 8, 'h7fff));
      emit(enc(op_sub, 10, 9, 3));
      emit(enc(op_lsl_i, 11, 2, 28));
      emit(enc(op_add, 12, 11, 11));
   endtask

   task automatic mem_prog();
      emit(enc(op_or_i, 1, 1, 'h0100));
      emit(enc(op_or_i, 2, 2, 'h0200));
      emit(enc(op_or_i, 3, 3, 'h1234));
      for (int i = 3; i < n_mem; i++) begin
         prog_rng = lcg_next(prog_rng);
         emit(enc(opcode_t'(prog_rng[31] ? op_ldw : op_stw), 3 + int'(prog_rng[28:24]) % 29,
                  1 + int'(prog_rng[20]), int'(prog_rng[9:0]) & 'h3fc));
      end
   endtask

   // Often reads the register written just before
   task automatic random_prog();
      logic [iw-1:0] w;
      logic [4:0]    prev;
      prev = '0;
      for (int i = 0; i < n_rand; i++) begin
         prog_rng = lcg_next(prog_rng);
         w = prog_rng;
         prog_rng = lcg_next(prog_rng);
         w[opc_msb:opc_lsb] = 6'(int'(prog_rng[31:24]) % 20);
         if (prog_rng[7]) begin
            w[rs1_msb:rs1_lsb] = prev;
         end
         if (prog_rng[9]) begin
            w[rs2_msb:rs2_lsb] = prev;
         end
         prev = w[rd_msb:rd_lsb];
         emit(w);
      end
   endtask

   // Dump all registers with r0 cleared as the base
   task automatic add_tail();
      emit(enc(op_stw, 0, 0, 1024));
      emit(enc(op_and_i, 0, 0, 0));
      for (int r = 1; r < 32; r++) begin
         emit(enc(op_stw, r, 0, 1024 + 4 * r));
      end
   endtask

   task automatic run_test(input string name, input int kind);
      int errs_before;
      @(posedge clk);
      #1;
      rst_n = 1'b0;
      prog_len = 0;
      case (kind)
         0: logic_prog();
         1: arith_prog();
         2: mem_prog();
         default: random_prog();
      endcase
      add_tail();
      for (int i = 0; i < prog_len; i++) begin
         u_checker.set_word(i, prog[i]);
      end
      u_checker.start_test(prog_len);
      errs_before = err_cnt + tb_errors;
      repeat (10) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(negedge clk);
      if (iaddr_o !== reset_vector || dbus_rd_o !== 1'b0 || dbus_we_o !== 1'b0 ||
          ibus_rd_o !== 1'b1) begin
         $display("FAIL %0t: state after reset wrong, iaddr_o %h ibus_rd_o %b", $time,
                  iaddr_o, ibus_rd_o);
         tb_errors++;
      end
      @(negedge clk);
      if (dbus_rd_o !== 1'b0 || dbus_we_o !== 1'b0) begin
         $display("FAIL %0t: data bus active before a memory op", $time);
         tb_errors++;
      end
      while (store_cnt < exp_cnt) begin
         @(posedge clk);
      end
      repeat (4) @(posedge clk);
      tests_run++;
      if (err_cnt + tb_errors != errs_before) begin
         tests_failed++;
         $display("%s: %0d stores checked, mismatches found", name, store_cnt);
      end else begin
         $display("%s: %0d stores checked, ok", name, store_cnt);
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   ////////////////////////////////////////
   // Data bus and fetch ready model
   ////////////////////////////////////////
   initial begin
      logic [31:0] bus_rng;
      logic        rst_seen;
      logic        bus_active;
      logic        ack_given;
      int          wait_cnt;
      d_i = '0;
      insn_ready = 1'b1;
      dbus_rd_ready = 1'b0;
      dbus_we_done = 1'b0;
      bus_rng = lcg_next(seed);
      bus_active = 1'b0;
      ack_given = 1'b0;
      wait_cnt = 0;
      forever begin
         @(posedge clk);
         rst_seen = rst_n;
         #1;
         dbus_rd_ready = 1'b0;
         dbus_we_done = 1'b0;
         if (!rst_seen) begin
            insn_ready = 1'b1;
            bus_active = 1'b0;
            ack_given = 1'b0;
         end else begin
            if (ack_given) begin
               bus_active = 1'b0;
               ack_given = 1'b0;
            end
            if ((dbus_rd_o || dbus_we_o) && !bus_active) begin
               bus_rng = lcg_next(bus_rng);
               bus_active = 1'b1;
               wait_cnt = int'(bus_rng[31:30]);
            end
            if (bus_active) begin
               if (wait_cnt == 0) begin
                  if (dbus_rd_o) begin
                     dbus_rd_ready = 1'b1;
                     d_i = load_data(addr_o);
                  end else begin
                     dbus_we_done = 1'b1;
                  end
                  ack_given = 1'b1;
               end else begin
                  wait_cnt--;
               end
            end
            bus_rng = lcg_next(bus_rng);
            insn_ready = !(fetch_may_drop() && bus_rng[29:28] == 2'b00);
         end
      end
   end

   initial begin
      repeat (limit_cycles) @(posedge clk);
      $display("Timeout: the tests did not finish within %0d cycles", limit_cycles);
      $display("=== FAIL ===");
      $finish;
   end

   initial begin
      rst_n = 1'b0;
      prog_len = 0;
      prog_rng = seed;
      tb_errors = 0;
      tests_run = 0;
      tests_failed = 0;
      run_test("logic", 0);
      run_test("arith", 1);
      run_test("load_store", 2);
      run_test("random", 3);
      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
               err_cnt + tb_errors);
      if (tests_failed == 0 && err_cnt == 0 && tb_errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

/* vlog.f */
common/ncpu_pkg.sv
common/ncpu_regf_if.sv
common/ncpu_dec_exe_if.sv
execute/ncpu_logic_unit.sv
execute/ncpu_execute.sv
src/ncpu_fetch.sv
src/ncpu_decode.sv
src/ncpu_regfile.sv
src/ncpu_core.sv
testbench/ncpu_checker.sv
testbench/tb_ncpu_core.sv
